//--- source/sap_macros.svh
// --------------------------------------------------
// SAP-1 size macros
// Data, address and memory depth for the core
// --------------------------------------------------
`ifndef SAP_MACROS_SVH
`define SAP_MACROS_SVH

// Data bus and instruction word width
`define SAP_DATA_W 8

// Memory address and operand width
`define SAP_ADDR_W 4

// Words in program memory
`define SAP_RAM_DEPTH 16

`endif

//--- source/sap_pkg.sv
// --------------------------------------------------
// SAP-1 shared types
// Data and address words, opcodes, sequencer
// stages and the microcode control word
// --------------------------------------------------
`include "sap_macros.svh"

package sap_pkg;

    typedef logic [`SAP_DATA_W-1:0] data_t;
    typedef logic [`SAP_ADDR_W-1:0] addr_t;

    // Upper nibble of the instruction word, 8 to 15 run as NOP
    typedef enum logic [`SAP_DATA_W-`SAP_ADDR_W-1:0] {
        HLT = 4'd0,
        NOP = 4'd1,
        ADD = 4'd2,
        SUB = 4'd3,
        LDA = 4'd4,
        OUT = 4'd5,
        STA = 4'd6,
        JMP = 4'd7
    } opcode_t;

    typedef enum logic [2:0] {
        T0     = 3'd0,
        T1     = 3'd1,
        T2     = 3'd2,
        T3     = 3'd3,
        T4     = 3'd4,
        T5     = 3'd5,
        S_HOLD = 3'd6,  // Held in reset
        S_HALT = 3'd7   // Stopped by HLT
    } stage_t;

    // All controls active high
    typedef struct packed {
        logic pc_inc;
        logic pc_out;
        logic pc_load;
        logic mar_load;
        logic ram_out;
        logic ram_load;
        logic ir_load;
        logic ir_out;
        logic a_load;
        logic a_out;
        logic alu_sub;
        logic alu_out;
        logic b_load;
        logic out_load;
        logic spare;    // Reserved
    } ctrl_word_t;

endpackage

//--- source/control_sequencer.sv
// --------------------------------------------------
// SAP-1 control sequencer
// Six-stage counter with halt flag; decodes
// stage and opcode into the control word
// --------------------------------------------------
`timescale 1ns/1ps

module control_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  sap_pkg::opcode_t    opcode,
    output sap_pkg::ctrl_word_t ctrl,
    output logic                halted
);

    import sap_pkg::*;

    stage_t stage;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage  <= S_HOLD;
            halted <= 1'b0;
        end else begin
            case (stage)
                S_HOLD: stage <= T0;
                T0:     stage <= T1;
                T1:     stage <= T2;
                T2:     stage <= T3;
                T3: begin
                    if (opcode == HLT) begin
                        stage  <= S_HALT;
                        halted <= 1'b1;
                    end else begin
                        stage <= T4;
                    end
                end
                T4:     stage <= T5;
                T5:     stage <= T0;
                default: stage <= S_HALT;  // Parked until reset
            endcase
        end
    end

    // Microcode ROM
    always_comb begin
        ctrl = '0;
        case (stage)
            T0: begin
                ctrl.pc_out   = 1'b1;  // PC to MAR
                ctrl.mar_load = 1'b1;
            end
            T1: begin
                ctrl.pc_inc = 1'b1;
            end
            T2: begin
                ctrl.ram_out = 1'b1;  // Fetch into IR
                ctrl.ir_load = 1'b1;
            end
            T3: begin
                case (opcode)
                    ADD, SUB, LDA, STA: begin
                        ctrl.ir_out   = 1'b1;  // Operand address to MAR
                        ctrl.mar_load = 1'b1;
                    end
                    OUT: begin
                        ctrl.a_out    = 1'b1;
                        ctrl.out_load = 1'b1;
                    end
                    JMP: begin
                        ctrl.ir_out  = 1'b1;
                        ctrl.pc_load = 1'b1;
                    end
                    default: ;  // HLT and NOP types idle
                endcase
            end
            T4: begin
                case (opcode)
                    ADD, SUB: begin
                        ctrl.ram_out = 1'b1;
                        ctrl.b_load  = 1'b1;
                    end
                    LDA: begin
                        ctrl.ram_out = 1'b1;
                        ctrl.a_load  = 1'b1;
                    end
                    STA: begin
                        ctrl.a_out = 1'b1;  // Write data on bus
                    end
                    default: ;
                endcase
            end
            T5: begin
                case (opcode)
                    ADD: begin
                        ctrl.alu_out = 1'b1;
                        ctrl.a_load  = 1'b1;
                    end
                    SUB: begin
                        ctrl.alu_sub = 1'b1;
                        ctrl.alu_out = 1'b1;
                        ctrl.a_load  = 1'b1;
                    end
                    STA: begin
                        ctrl.a_out    = 1'b1;
                        ctrl.ram_load = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;  // S_HOLD and S_HALT drive nothing
        endcase
    end

    // Once halted, only reset restarts the core
    assert property (@(posedge clk)
        (rst_n && stage == S_HALT) |=> (stage == S_HALT));

    // Single driver on the shared bus
    assert property (@(posedge clk)
        $onehot0({ctrl.pc_out, ctrl.ir_out, ctrl.ram_out, ctrl.a_out, ctrl.alu_out}));

endmodule

//--- source/address_unit.sv
// --------------------------------------------------
// SAP-1 address unit
// Program counter, memory address register and
// instruction register, all loaded from the bus
// --------------------------------------------------
`timescale 1ns/1ps
`include "sap_macros.svh"

module address_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  sap_pkg::ctrl_word_t ctrl,
    input  sap_pkg::data_t      bus,
    output sap_pkg::addr_t      pc,
    output sap_pkg::addr_t      mar,
    output sap_pkg::addr_t      operand,
    output sap_pkg::opcode_t    opcode
);

    import sap_pkg::*;

    data_t ir;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (ctrl.pc_load) begin
            pc <= bus[`SAP_ADDR_W-1:0];  // Jump target
        end else if (ctrl.pc_inc) begin
            pc <= pc + addr_t'(1);  // Wraps at 16
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (ctrl.mar_load) begin
            mar <= bus[`SAP_ADDR_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (ctrl.ir_load) begin
            ir <= bus;
        end
    end

    // Opcode in the upper nibble, address in the lower
    assign opcode  = opcode_t'(ir[`SAP_DATA_W-1:`SAP_ADDR_W]);
    assign operand = ir[`SAP_ADDR_W-1:0];

    assert property (@(posedge clk) !(ctrl.pc_inc && ctrl.pc_load));

endmodule

//--- source/program_memory.sv
// --------------------------------------------------
// SAP-1 program memory
// 16x8 RAM read at the MAR; written by the core
// on ram_load or by the loader while in reset
// --------------------------------------------------
`timescale 1ns/1ps
`include "sap_macros.svh"

module program_memory (
    input  logic                clk,
    input  logic                rst_n,
    input  sap_pkg::ctrl_word_t ctrl,
    input  sap_pkg::addr_t      mar,
    input  sap_pkg::data_t      wdata,
    output sap_pkg::data_t      rdata,
    input  logic                prog_we,
    input  sap_pkg::addr_t      prog_addr,
    input  sap_pkg::data_t      prog_data
);

    import sap_pkg::*;

    data_t mem [`SAP_RAM_DEPTH];

    assign rdata = mem[mar];  // Asynchronous read

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;  // Loader port
        end else if (ctrl.ram_load) begin
            mem[mar] <= wdata;  // STA
        end
    end

    // The loader only runs while the core is in reset
    assert property (@(posedge clk) rst_n |-> !prog_we);

endmodule

//--- source/datapath.sv
// --------------------------------------------------
// SAP-1 datapath
// Bus source mux, accumulator and B register,
// 8-bit adder/subtractor and output register
// --------------------------------------------------
`timescale 1ns/1ps

module datapath (
    input  logic                clk,
    input  logic                rst_n,
    input  sap_pkg::ctrl_word_t ctrl,
    input  sap_pkg::addr_t      pc,
    input  sap_pkg::addr_t      operand,
    input  sap_pkg::data_t      ram_rdata,
    output sap_pkg::data_t      bus,
    output logic                out_valid,
    output sap_pkg::data_t      out_data
);

    import sap_pkg::*;

    data_t a_reg;
    data_t b_reg;
    data_t alu_result;

    // Modulo 256 in both directions
    assign alu_result = ctrl.alu_sub ? (a_reg - b_reg) : (a_reg + b_reg);

    // At most one source is enabled per stage
    always_comb begin
        if (ctrl.pc_out) begin
            bus = data_t'(pc);  // Zero extended
        end else if (ctrl.ir_out) begin
            bus = data_t'(operand);
        end else if (ctrl.ram_out) begin
            bus = ram_rdata;
        end else if (ctrl.a_out) begin
            bus = a_reg;
        end else if (ctrl.alu_out) begin
            bus = alu_result;
        end else begin
            bus = '0;  // Idle bus
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_reg <= '0;
        end else if (ctrl.a_load) begin
            a_reg <= bus;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            b_reg <= '0;
        end else if (ctrl.b_load) begin
            b_reg <= bus;
        end
    end

    // Output register with a one-cycle strobe per new value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_data  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= ctrl.out_load;
            if (ctrl.out_load) begin
                out_data <= bus;  // A is on the bus in OUT T3
            end
        end
    end

endmodule

//--- source/sap_cpu_top.sv
// --------------------------------------------------
// SAP-1 processor top level
// Sequencer, address unit, program memory and
// datapath around the shared bus
// --------------------------------------------------
`timescale 1ns/1ps

module sap_cpu_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           prog_we,
    input  sap_pkg::addr_t prog_addr,
    input  sap_pkg::data_t prog_data,
    output logic           out_valid,
    output sap_pkg::data_t out_data,
    output logic           halted
);

    import sap_pkg::*;

    ctrl_word_t ctrl;
    opcode_t    opcode;
    data_t      bus;
    data_t      ram_rdata;
    addr_t      pc;
    addr_t      mar;
    addr_t      operand;

    control_sequencer u_seq (
        .clk    (clk),
        .rst_n  (rst_n),
        .opcode (opcode),
        .ctrl   (ctrl),
        .halted (halted)
    );

    address_unit u_addr (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl),
        .bus     (bus),
        .pc      (pc),
        .mar     (mar),
        .operand (operand),
        .opcode  (opcode)
    );

    program_memory u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .mar       (mar),
        .wdata     (bus),       // STA writes from the bus
        .rdata     (ram_rdata),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data)
    );

    datapath u_dp (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .pc        (pc),
        .operand   (operand),
        .ram_rdata (ram_rdata),
        .bus       (bus),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

//--- dv/sap_cpu_tb.sv
// --------------------------------------------------
// SAP-1 processor testbench
// Loads directed programs through the loader port,
// runs them and compares the output strobes with
// a software interpreter of the instruction set
// --------------------------------------------------
`timescale 1ns/1ps
`include "sap_macros.svh"

module sap_cpu_tb;

    import sap_pkg::*;

    localparam int RUN_TIMEOUT = 1000;  // Cycles from reset release to halted

    logic  clk;
    logic  rst_n;
    logic  prog_we;
    addr_t prog_addr;
    data_t prog_data;
    logic  out_valid;
    data_t out_data;
    logic  halted;

    integer seed;
    data_t  image [`SAP_RAM_DEPTH];
    data_t  got_q [$];
    data_t  exp_q [$];
    int     halt_cycles;  // Cycles from reset release to halted

    sap_cpu_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halted    (halted)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_cycles(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic data_t instr(input opcode_t op, input addr_t operand);
        return {op, operand};
    endfunction

    function automatic data_t rand_data();
        return data_t'($random(seed));
    endfunction

    // Unused words are HLT with the word's own address as operand
    task automatic clear_image();
        int i;
        for (i = 0; i < `SAP_RAM_DEPTH; i++) begin
            image[i] = {HLT, addr_t'(i)};
        end
    endtask

    // Writes the image while in reset, then holds reset for 16 cycles
    task automatic load_program();
        int i;
        @(negedge clk);
        rst_n = 1'b0;
        for (i = 0; i < `SAP_RAM_DEPTH; i++) begin
            prog_we   = 1'b1;
            prog_addr = addr_t'(i);
            prog_data = image[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        repeat (16) begin
            @(negedge clk);
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("halted", halted, 1'b0);
        end
    endtask

    // Instruction-level interpreter of the same image
    task automatic run_model();
        data_t mem [`SAP_RAM_DEPTH];
        addr_t pc;
        addr_t opnd;
        data_t a;
        data_t ir;
        int    steps;
        bit    done;
        mem = image;
        exp_q.delete();
        pc    = '0;
        a     = '0;
        steps = 0;
        done  = 1'b0;
        while (!done) begin
            ir   = mem[pc];
            pc   = pc + 4'd1;
            opnd = ir[3:0];
            case (opcode_t'(ir[7:4]))
                HLT: done = 1'b1;
                ADD: a = a + mem[opnd];
                SUB: a = a - mem[opnd];
                LDA: a = mem[opnd];
                OUT: exp_q.push_back(a);
                STA: mem[opnd] = a;
                JMP: pc = opnd;
                default: ;  // NOP and opcodes 8 to 15
            endcase
            steps++;
            if (steps > 256) begin
                abort_run("Reference model never reached HLT");
            end
        end
    endtask

    task automatic run_until_halt();
        int cycles;
        got_q.delete();
        cycles = 0;
        rst_n  = 1'b1;
        do begin
            @(negedge clk);
            if (out_valid) begin
                got_q.push_back(out_data);
            end
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                abort_run("Timed out waiting for halted after reset release");
            end
        end while (!halted);
        halt_cycles = cycles;
    endtask

    task automatic run_and_compare();
        int i;
        load_program();
        run_model();
        run_until_halt();
        if (got_q.size() != exp_q.size()) begin
            abort_run($sformatf("Got %0d output strobes but expected %0d",
                                got_q.size(), exp_q.size()));
        end
        for (i = 0; i < exp_q.size(); i++) begin
            check_data("out_data", got_q[i], exp_q[i]);
        end
    endtask

    task automatic test_reset_halt();
        clear_image();  // Word 0 is HLT
        run_and_compare();
        // S_HOLD plus T0 to T3 of HLT
        compare_cycles("cycles to halted", halt_cycles, 5);
    endtask

    task automatic test_lda_out();
        int i;
        clear_image();
        for (i = 0; i < 4; i++) begin
            image[2*i]   = instr(LDA, addr_t'(10 + i));
            image[2*i+1] = instr(OUT, 4'h0);
            image[10+i]  = rand_data();
        end
        run_and_compare();
    endtask

    task automatic test_add_sub(input data_t d0, input data_t d1, input data_t d2,
                                input data_t d3);
        clear_image();
        image[0]  = instr(LDA, 4'd12);
        image[1]  = instr(ADD, 4'd13);
        image[2]  = instr(OUT, 4'd0);
        image[3]  = instr(SUB, 4'd14);
        image[4]  = instr(OUT, 4'd0);
        image[5]  = instr(ADD, 4'd15);
        image[6]  = instr(OUT, 4'd0);
        image[7]  = instr(SUB, 4'd12);
        image[8]  = instr(OUT, 4'd0);
        image[12] = d0;
        image[13] = d1;
        image[14] = d2;
        image[15] = d3;
        run_and_compare();
    endtask

    task automatic test_sta_round_trip();
        data_t sum;
        clear_image();
        image[0]  = instr(LDA, 4'd12);
        image[1]  = instr(ADD, 4'd13);
        image[2]  = instr(STA, 4'd15);
        image[3]  = instr(LDA, 4'd14);  // Clear A
        image[4]  = instr(OUT, 4'd0);
        image[5]  = instr(LDA, 4'd15);
        image[6]  = instr(OUT, 4'd0);
        image[12] = rand_data();
        image[13] = rand_data();
        image[14] = 8'h00;
        image[15] = rand_data();  // Overwritten by STA
        sum = image[12] + image[13];
        run_and_compare();
        check_data("stored word", got_q[1], sum);
    endtask

    task automatic test_jmp_undefined();
        int run;
        for (run = 0; run < 3; run++) begin
            clear_image();
            image[0]  = instr(LDA, 4'd14);
            image[1]  = instr(OUT, 4'd0);
            image[2]  = instr(JMP, 4'd4);
            image[3]  = instr(OUT, 4'd0);  // Skipped
            image[4]  = instr(NOP, 4'd13);
            image[5]  = {4'h8 + 4'((3 * run) % 8), 4'hf};
            image[6]  = {4'h8 + 4'((3 * run + 1) % 8), 4'he};
            image[7]  = {4'h8 + 4'((3 * run + 2) % 8), 4'hd};
            image[8]  = instr(ADD, 4'd15);
            image[9]  = instr(OUT, 4'd0);
            image[14] = rand_data();
            image[15] = rand_data();
            run_and_compare();
        end
    endtask

    task automatic test_halt_holds();
        clear_image();
        image[0]  = instr(LDA, 4'd15);
        image[1]  = instr(OUT, 4'd0);
        image[15] = rand_data();
        run_and_compare();
        repeat (50) begin
            @(negedge clk);
            check_flag("halted", halted, 1'b1);
            check_flag("out_valid", out_valid, 1'b0);
        end
        rst_n = 1'b0;
        @(negedge clk);
        check_flag("halted", halted, 1'b0);
    endtask

    initial begin
        seed      = 32'hdacb_7ba0;
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        test_reset_halt();
        test_lda_out();
        test_add_sub(8'hf0, 8'h30, 8'h80, 8'hc5);  // Wraps both ways
        test_add_sub(rand_data(), rand_data(), rand_data(), rand_data());
        test_add_sub(rand_data(), rand_data(), rand_data(), rand_data());
        test_sta_round_trip();
        test_jmp_undefined();
        test_halt_holds();
        $display("All tests passed");
        $finish;
    end

endmodule

//--- build.f
+incdir+source
source/sap_pkg.sv
source/control_sequencer.sv
source/address_unit.sv
source/program_memory.sv
source/datapath.sv
source/sap_cpu_top.sv
dv/sap_cpu_tb.sv

//--- run.sh
#!/bin/sh
# Compile the SAP-1 testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f build.f --top-module sap_cpu_tb -o sap_cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/sap_cpu_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All tests passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
